//--- rtl/backend_config.svh
`ifndef BACKEND_CONFIG_SVH
`define BACKEND_CONFIG_SVH

//////////////////////////////////////////////////
// back end sizing
//////////////////////////////////////////////////

// lanes per dispatch row, power of two
`define ID_WIDTH 2

// rows in the reorder buffer, power of two
`define ROB_DEPTH 8

`define CDB_WIDTH 2     // completion broadcast ports

`define PRF_DEPTH 64    // physical registers

`define CB_DEPTH 4      // branch entries in flight

`endif

//--- rtl/backend_pkg.sv
`default_nettype none

`include "backend_config.svh"

package backend_pkg;

    localparam int LANE_BITS = $clog2(`ID_WIDTH);
    localparam int ROW_BITS  = $clog2(`ROB_DEPTH);
    localparam int TAG_BITS  = ROW_BITS + LANE_BITS;
    localparam int PRF_BITS  = $clog2(`PRF_DEPTH);

    typedef logic [PRF_BITS-1:0] phy_reg_t;
    typedef logic [4:0]          arch_reg_t;

    // row in the upper bits, lane in the lower
    typedef struct packed {
        logic [ROW_BITS-1:0]  row;
        logic [LANE_BITS-1:0] lane;
    } rob_row_lane_t;

    // seq is what dispatch hands out, rl is what the buffers index by
    typedef union packed {
        logic [TAG_BITS-1:0] seq;
        rob_row_lane_t       rl;
    } rob_tag_u;

endpackage

`default_nettype wire

//--- rtl/backend_itf.sv
`timescale 1ns/1ps
`default_nettype none

`include "backend_config.svh"

//////////////////////////////////////////////////
// dispatch to reorder buffer
//////////////////////////////////////////////////

interface id_rob_itf;

    logic                                      valid;
    logic                                      ready;   // not full
    logic [`ID_WIDTH-1:0]                      inst_valid;
    backend_pkg::phy_reg_t [`ID_WIDTH-1:0]     rd_phy;
    backend_pkg::arch_reg_t [`ID_WIDTH-1:0]    rd_arch;
    backend_pkg::rob_tag_u [`ID_WIDTH-1:0]     rob_tag; // from the tail row

    modport id (
        output valid,
        output inst_valid,
        output rd_phy,
        output rd_arch,
        input  ready,
        input  rob_tag
    );

    modport rob (
        input  valid,
        input  inst_valid,
        input  rd_phy,
        input  rd_arch,
        output ready,
        output rob_tag
    );

endinterface

//////////////////////////////////////////////////
// control buffer head to reorder buffer
//////////////////////////////////////////////////

interface cb_rob_itf;

    logic                  head_ready;      // head valid and resolved
    backend_pkg::rob_tag_u head_tag;
    logic                  miss_predict;
    logic [31:0]           target_address;
    logic                  dequeue;         // one cycle strobe

    modport cb (
        output head_ready,
        output head_tag,
        output miss_predict,
        output target_address,
        input  dequeue
    );

    modport rob (
        input  head_ready,
        input  head_tag,
        input  miss_predict,
        input  target_address,
        output dequeue
    );

endinterface

`default_nettype wire

//--- rtl/rob.sv
`timescale 1ns/1ps
`default_nettype none

`include "backend_config.svh"

module rob (
    input  logic                                   clk,
    input  logic                                   rst,

    id_rob_itf.rob                                 from_id,

    input  logic [`CDB_WIDTH-1:0]                  cdb_valid,
    input  backend_pkg::rob_tag_u [`CDB_WIDTH-1:0] cdb_tag,

    output logic [`ID_WIDTH-1:0]                   commit_valid,
    output backend_pkg::phy_reg_t [`ID_WIDTH-1:0]  commit_rd_phy,
    output backend_pkg::arch_reg_t [`ID_WIDTH-1:0] commit_rd_arch,

    cb_rob_itf.rob                                 cb,

    output logic                                   backend_flush,
    output logic [31:0]                            backend_redirect_pc
);

    localparam int ROW_W  = backend_pkg::ROW_BITS;
    localparam int LANE_W = backend_pkg::LANE_BITS;

    // per row lane state
    logic [`ROB_DEPTH-1:0][`ID_WIDTH-1:0] valid_q;
    logic [`ROB_DEPTH-1:0][`ID_WIDTH-1:0] ready_q;

    backend_pkg::phy_reg_t  rd_phy_q  [`ROB_DEPTH][`ID_WIDTH];
    backend_pkg::arch_reg_t rd_arch_q [`ROB_DEPTH][`ID_WIDTH];

    logic [ROW_W:0]   head_q;   // wrap flag in msb
    logic [ROW_W:0]   tail_q;
    logic [ROW_W-1:0] head_row;
    logic [ROW_W-1:0] tail_row;
    logic             head_wrap;
    logic             tail_wrap;

    logic full;
    logic empty;
    logic push;
    logic pop;
    logic dequeue;

    assign {head_wrap, head_row} = head_q;
    assign {tail_wrap, tail_row} = tail_q;

    assign full  = (head_row == tail_row) && (head_wrap != tail_wrap);
    assign empty = (head_row == tail_row) && (head_wrap == tail_wrap);

    assign push = from_id.valid && from_id.ready;
    // head row leaves once no valid lane is still waiting
    assign pop  = !empty && ((valid_q[head_row] & ~ready_q[head_row]) == '0);

    //////////////////////////////////////////////////
    // dispatch side
    //////////////////////////////////////////////////

    assign from_id.ready = !full;

    always_comb begin
        for (int i = 0; i < `ID_WIDTH; i++) begin
            from_id.rob_tag[i].rl.row  = tail_row;
            from_id.rob_tag[i].rl.lane = LANE_W'(i);
        end
    end

    always_ff @(posedge clk) begin
        if (rst || backend_flush) begin
            head_q  <= '0;
            tail_q  <= '0;
            valid_q <= '0;
            ready_q <= '0;
        end else begin
            if (push) begin
                tail_q            <= tail_q + (ROW_W + 1)'(1);
                valid_q[tail_row] <= from_id.inst_valid;
                ready_q[tail_row] <= '0;
            end
            if (pop) begin
                head_q <= head_q + (ROW_W + 1)'(1);
            end
            for (int k = 0; k < `CDB_WIDTH; k++) begin   // snoop CDB
                if (cdb_valid[k]) begin
                    ready_q[cdb_tag[k].rl.row][cdb_tag[k].rl.lane] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            for (int i = 0; i < `ID_WIDTH; i++) begin
                rd_phy_q[tail_row][i]  <= from_id.rd_phy[i];
                rd_arch_q[tail_row][i] <= from_id.rd_arch[i];
            end
        end
    end

    //////////////////////////////////////////////////
    // commit and branch retire
    //////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < `ID_WIDTH; i++) begin
            commit_valid[i]   = pop && valid_q[head_row][i];
            commit_rd_phy[i]  = rd_phy_q[head_row][i];
            commit_rd_arch[i] = rd_arch_q[head_row][i];
        end
    end

    // oldest resolved branch sits in the row going out
    assign dequeue    = cb.head_ready && pop && (cb.head_tag.rl.row == head_row);
    assign cb.dequeue = dequeue;

    assign backend_flush       = dequeue && cb.miss_predict;
    assign backend_redirect_pc = cb.target_address;

endmodule

`default_nettype wire

//--- rtl/rrf.sv
`timescale 1ns/1ps
`default_nettype none

`include "backend_config.svh"

module rrf (
    input  logic                                   clk,
    input  logic                                   rst,

    input  logic [`ID_WIDTH-1:0]                   commit_valid,
    input  backend_pkg::phy_reg_t [`ID_WIDTH-1:0]  commit_rd_phy,
    input  backend_pkg::arch_reg_t [`ID_WIDTH-1:0] commit_rd_arch,

    output logic [`ID_WIDTH-1:0]                   free_valid,
    output backend_pkg::phy_reg_t [`ID_WIDTH-1:0]  free_phy
);

    localparam int ARCH_REGS = 2 ** $bits(backend_pkg::arch_reg_t);

    backend_pkg::phy_reg_t map_q [ARCH_REGS];

    //////////////////////////////////////////////////
    // displaced register per lane
    //////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < `ID_WIDTH; i++) begin
            free_valid[i] = commit_valid[i] && (commit_rd_arch[i] != '0);  // x0 never frees
            free_phy[i]   = map_q[commit_rd_arch[i]];
            // nearest earlier lane of the same row overrides the table
            for (int j = 0; j < i; j++) begin
                if (commit_valid[j] && (commit_rd_arch[j] == commit_rd_arch[i])) begin
                    free_phy[i] = commit_rd_phy[j];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < ARCH_REGS; r++) begin
                map_q[r] <= backend_pkg::phy_reg_t'(r);   // identity map
            end
        end else begin
            for (int i = 0; i < `ID_WIDTH; i++) begin   // later lane wins
                if (commit_valid[i] && (commit_rd_arch[i] != '0)) begin
                    map_q[commit_rd_arch[i]] <= commit_rd_phy[i];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/control_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "backend_config.svh"

module control_buffer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  backend_flush,

    input  logic                  br_push,
    input  backend_pkg::rob_tag_u br_tag,
    output logic                  br_ready,

    input  logic                  br_resolve,
    input  backend_pkg::rob_tag_u br_resolve_tag,
    input  logic                  br_miss,
    input  logic [31:0]           br_target,

    cb_rob_itf.cb                 to_rob
);

    localparam int IDX_W = $clog2(`CB_DEPTH);

    logic [`CB_DEPTH-1:0] valid_q;
    logic [`CB_DEPTH-1:0] resolved_q;

    backend_pkg::rob_tag_u tag_q    [`CB_DEPTH];
    logic                  miss_q   [`CB_DEPTH];
    logic [31:0]           target_q [`CB_DEPTH];

    logic [IDX_W:0]   head_q;
    logic [IDX_W:0]   tail_q;
    logic [IDX_W-1:0] head_idx;
    logic [IDX_W-1:0] tail_idx;
    logic             head_wrap;
    logic             tail_wrap;
    logic             full;
    logic             push;

    assign {head_wrap, head_idx} = head_q;
    assign {tail_wrap, tail_idx} = tail_q;

    assign full     = (head_idx == tail_idx) && (head_wrap != tail_wrap);
    assign br_ready = !full;
    assign push     = br_push && br_ready;   // push while full is dropped

    always_ff @(posedge clk) begin
        if (rst || backend_flush) begin
            head_q     <= '0;
            tail_q     <= '0;
            valid_q    <= '0;
            resolved_q <= '0;
        end else begin
            if (push) begin
                tail_q               <= tail_q + (IDX_W + 1)'(1);
                valid_q[tail_idx]    <= 1'b1;
                resolved_q[tail_idx] <= 1'b0;
            end
            if (to_rob.dequeue) begin
                head_q            <= head_q + (IDX_W + 1)'(1);
                valid_q[head_idx] <= 1'b0;
            end
            for (int i = 0; i < `CB_DEPTH; i++) begin   // resolve by tag match
                if (br_resolve && valid_q[i] && (tag_q[i].seq == br_resolve_tag.seq)) begin
                    resolved_q[i] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            tag_q[tail_idx] <= br_tag;
        end
        for (int i = 0; i < `CB_DEPTH; i++) begin
            if (br_resolve && valid_q[i] && (tag_q[i].seq == br_resolve_tag.seq)) begin
                miss_q[i]   <= br_miss;
                target_q[i] <= br_target;
            end
        end
    end

    // head feeds the rob
    assign to_rob.head_ready     = valid_q[head_idx] && resolved_q[head_idx];
    assign to_rob.head_tag       = tag_q[head_idx];
    assign to_rob.miss_predict   = miss_q[head_idx];
    assign to_rob.target_address = target_q[head_idx];

endmodule

`default_nettype wire

//--- rtl/rob_backend.sv
`timescale 1ns/1ps
`default_nettype none

`include "backend_config.svh"

module rob_backend (
    input  logic                                   clk,
    input  logic                                   rst,

    // dispatch
    input  logic                                   disp_valid,
    output logic                                   disp_ready,
    input  logic [`ID_WIDTH-1:0]                   disp_inst_valid,
    input  backend_pkg::phy_reg_t [`ID_WIDTH-1:0]  disp_rd_phy,
    input  backend_pkg::arch_reg_t [`ID_WIDTH-1:0] disp_rd_arch,
    output backend_pkg::rob_tag_u [`ID_WIDTH-1:0]  disp_tag,

    // completion
    input  logic [`CDB_WIDTH-1:0]                  cdb_valid,
    input  backend_pkg::rob_tag_u [`CDB_WIDTH-1:0] cdb_tag,

    // branch
    input  logic                                   br_push,
    input  backend_pkg::rob_tag_u                  br_tag,
    output logic                                   br_ready,
    input  logic                                   br_resolve,
    input  backend_pkg::rob_tag_u                  br_resolve_tag,
    input  logic                                   br_miss,
    input  logic [31:0]                            br_target,

    // commit and free
    output logic [`ID_WIDTH-1:0]                   commit_valid,
    output backend_pkg::phy_reg_t [`ID_WIDTH-1:0]  commit_rd_phy,
    output backend_pkg::arch_reg_t [`ID_WIDTH-1:0] commit_rd_arch,
    output logic [`ID_WIDTH-1:0]                   free_valid,
    output backend_pkg::phy_reg_t [`ID_WIDTH-1:0]  free_phy,

    // flush
    output logic                                   backend_flush,
    output logic [31:0]                            backend_redirect_pc
);

    id_rob_itf id_rob ();
    cb_rob_itf cb_rob ();

    // dispatch side of the rob link
    assign id_rob.valid      = disp_valid;
    assign id_rob.inst_valid = disp_inst_valid;
    assign id_rob.rd_phy     = disp_rd_phy;
    assign id_rob.rd_arch    = disp_rd_arch;
    assign disp_ready        = id_rob.ready;
    assign disp_tag          = id_rob.rob_tag;

    rob u_rob (
        .clk                 (clk),
        .rst                 (rst),
        .from_id             (id_rob),
        .cdb_valid           (cdb_valid),
        .cdb_tag             (cdb_tag),
        .commit_valid        (commit_valid),
        .commit_rd_phy       (commit_rd_phy),
        .commit_rd_arch      (commit_rd_arch),
        .cb                  (cb_rob),
        .backend_flush       (backend_flush),
        .backend_redirect_pc (backend_redirect_pc)
    );

    rrf u_rrf (
        .clk            (clk),
        .rst            (rst),
        .commit_valid   (commit_valid),
        .commit_rd_phy  (commit_rd_phy),
        .commit_rd_arch (commit_rd_arch),
        .free_valid     (free_valid),
        .free_phy       (free_phy)
    );

    control_buffer u_control_buffer (
        .clk            (clk),
        .rst            (rst),
        .backend_flush  (backend_flush),
        .br_push        (br_push),
        .br_tag         (br_tag),
        .br_ready       (br_ready),
        .br_resolve     (br_resolve),
        .br_resolve_tag (br_resolve_tag),
        .br_miss        (br_miss),
        .br_target      (br_target),
        .to_rob         (cb_rob)
    );

endmodule

`default_nettype wire

//--- tests/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk
);

    initial clk = 1'b0;

    always #50 clk = ~clk;   // 100 ns period

endmodule

`default_nettype wire

//--- tests/rob_backend_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "backend_config.svh"

module rob_backend_checker (
    input wire logic                                  clk,
    input wire logic                                  rst,
    input wire logic                                  disp_ready,
    input wire backend_pkg::rob_tag_u [`ID_WIDTH-1:0] disp_tag,
    input wire logic [`ID_WIDTH-1:0]                  commit_valid,
    input wire logic [`ID_WIDTH-1:0]                  free_valid,
    input wire logic                                  backend_flush,
    input wire logic                                  br_ready
);

    //////////////////////////////////////////////////
    // reset and protocol properties
    //////////////////////////////////////////////////

    // control outputs idle right after reset
    assert property (@(posedge clk)
        rst |=> (commit_valid == '0) && (free_valid == '0) && !backend_flush
            && disp_ready && br_ready && (disp_tag[0].seq == '0))
    else $error("outputs not idle after reset");

    assert property (@(posedge clk) disable iff (rst)
        (free_valid & ~commit_valid) == '0)
    else $error("free_valid without commit_valid on the same lane");

    // flush empties the rob
    assert property (@(posedge clk) disable iff (rst)
        backend_flush |=> (disp_tag[0].seq == '0) && (commit_valid == '0))
    else $error("rob not empty after flush");

    assert property (@(posedge clk) disable iff (rst)
        (!disp_ready && !backend_flush) |=> $stable(disp_tag))
    else $error("dispatch tag moved while rob full");

endmodule

bind rob_backend rob_backend_checker i_checker (
    .clk           (clk),
    .rst           (rst),
    .disp_ready    (disp_ready),
    .disp_tag      (disp_tag),
    .commit_valid  (commit_valid),
    .free_valid    (free_valid),
    .backend_flush (backend_flush),
    .br_ready      (br_ready)
);

`default_nettype wire

//--- tests/rob_backend_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "backend_config.svh"

module rob_backend_tb;

    localparam int W          = `ID_WIDTH;
    localparam int TAGS       = `ROB_DEPTH * `ID_WIDTH;
    localparam int MAX_CYCLES = 3000;   // tests run about 600 cycles

    logic clk;
    logic rst;
    logic disp_valid;
    logic disp_ready;
    logic [W-1:0] disp_inst_valid;
    backend_pkg::phy_reg_t [W-1:0]  disp_rd_phy;
    backend_pkg::arch_reg_t [W-1:0] disp_rd_arch;
    backend_pkg::rob_tag_u [W-1:0]  disp_tag;
    logic [`CDB_WIDTH-1:0] cdb_valid;
    backend_pkg::rob_tag_u [`CDB_WIDTH-1:0] cdb_tag;
    logic br_push;
    backend_pkg::rob_tag_u br_tag;
    logic br_ready;
    logic br_resolve;
    backend_pkg::rob_tag_u br_resolve_tag;
    logic br_miss;
    logic [31:0] br_target;
    logic [W-1:0] commit_valid;
    backend_pkg::phy_reg_t [W-1:0]  commit_rd_phy;
    backend_pkg::arch_reg_t [W-1:0] commit_rd_arch;
    logic [W-1:0] free_valid;
    backend_pkg::phy_reg_t [W-1:0]  free_phy;
    logic backend_flush;
    logic [31:0] backend_redirect_pc;

    tb_clock u_clock (.clk(clk));

    rob_backend i_dut (.*);

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    int row_mask[$];
    int row_base[$];
    backend_pkg::phy_reg_t [W-1:0]  row_phy[$];
    backend_pkg::arch_reg_t [W-1:0] row_arch[$];
    bit done_tag[TAGS];
    int next_tag;
    int br_q_tag[$];
    bit br_q_res[$];
    bit br_q_miss[$];
    logic [31:0] br_q_target[$];
    backend_pkg::phy_reg_t arch_map[32];

    int pend[$];            // dispatched tags not yet completed
    bit br_wait[TAGS];      // branch tags still to resolve
    bit br_wait_miss[TAGS];
    logic [31:0] br_wait_target[TAGS];
    string test_name;
    int cycles;

    task automatic check_value(string what, longint exp, longint act);
        assert (exp == act) else begin
            $display("mismatch %s %s: expected %0h actual %0h", test_name, what, exp, act);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    endtask

    task automatic fail_plain(string msg);
        $display("%s: %s", test_name, msg);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles", MAX_CYCLES);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    end

    // outputs are stable mid cycle
    always @(negedge clk) begin : monitor
        int base;
        bit exp_flush;
        if (!rst) begin
            check_value("disp_ready", row_base.size() < `ROB_DEPTH, disp_ready);
            check_value("br_ready", br_q_tag.size() < `CB_DEPTH, br_ready);
            exp_flush = 1'b0;
            if (commit_valid != '0) begin
                if (row_base.size() == 0) fail_plain("commit with no row outstanding");
                base = row_base[0];
                check_value("commit_valid", row_mask[0], commit_valid);
                for (int i = 0; i < W; i++) begin
                    if (row_mask[0][i]) begin
                        check_value("lane completed", 1, done_tag[base + i]);
                        check_value("commit_rd_phy", row_phy[0][i], commit_rd_phy[i]);
                        check_value("commit_rd_arch", row_arch[0][i], commit_rd_arch[i]);
                    end
                    if (row_mask[0][i] && row_arch[0][i] != 0) begin
                        check_value("free_valid", 1, free_valid[i]);
                        check_value("free_phy", arch_map[row_arch[0][i]], free_phy[i]);
                        arch_map[row_arch[0][i]] = row_phy[0][i];
                    end else begin
                        check_value("free_valid", 0, free_valid[i]);
                    end
                end
                if (br_q_tag.size() != 0 && br_q_res[0] && (br_q_tag[0] / W == base / W)) begin
                    exp_flush = br_q_miss[0];
                    if (exp_flush) check_value("redirect_pc", br_q_target[0], backend_redirect_pc);
                    void'(br_q_tag.pop_front());
                    void'(br_q_res.pop_front());
                    void'(br_q_miss.pop_front());
                    void'(br_q_target.pop_front());
                end
                void'(row_mask.pop_front());
                void'(row_base.pop_front());
                void'(row_phy.pop_front());
                void'(row_arch.pop_front());
            end else begin
                check_value("free_valid", 0, free_valid);
            end
            check_value("backend_flush", exp_flush, backend_flush);
            if (exp_flush) begin   // younger rows and branches are gone
                row_mask.delete();
                row_base.delete();
                row_phy.delete();
                row_arch.delete();
                br_q_tag.delete();
                br_q_res.delete();
                br_q_miss.delete();
                br_q_target.delete();
                pend.delete();
                next_tag = 0;
            end else if (disp_valid && disp_ready) begin
                for (int i = 0; i < W; i++) begin
                    check_value("disp_tag", (next_tag + i) % TAGS, disp_tag[i].seq);
                    done_tag[next_tag + i] = 1'b0;
                end
                row_mask.push_back(disp_inst_valid);
                row_base.push_back(next_tag);
                row_phy.push_back(disp_rd_phy);
                row_arch.push_back(disp_rd_arch);
                next_tag = (next_tag + W) % TAGS;
                if (br_push && br_ready) begin
                    br_q_tag.push_back(br_tag.seq);
                    br_q_res.push_back(1'b0);
                    br_q_miss.push_back(1'b0);
                    br_q_target.push_back('0);
                end
            end
            for (int k = 0; k < `CDB_WIDTH; k++) begin
                if (cdb_valid[k]) done_tag[cdb_tag[k].seq] = 1'b1;
            end
            for (int j = 0; j < br_q_tag.size(); j++) begin
                if (br_resolve && br_q_tag[j] == br_resolve_tag.seq) begin
                    br_q_res[j]    = 1'b1;
                    br_q_miss[j]   = br_miss;
                    br_q_target[j] = br_target;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    task automatic tick();
        @(posedge clk);
        #10;
    endtask

    task automatic offer(logic [W-1:0] mask, int a0, int a1);
        disp_valid      = 1'b1;
        disp_inst_valid = mask;
        disp_rd_phy[0]  = backend_pkg::phy_reg_t'($urandom_range(`PRF_DEPTH - 1));
        disp_rd_phy[1]  = backend_pkg::phy_reg_t'($urandom_range(`PRF_DEPTH - 1));
        disp_rd_arch[0] = backend_pkg::arch_reg_t'(a0);
        disp_rd_arch[1] = backend_pkg::arch_reg_t'(a1);
    endtask

    // waits for ready, branch goes in the last valid lane
    task automatic accept(bit branch, bit miss);
        int last;
        while (!disp_ready || (branch && !br_ready)) tick();
        last = disp_inst_valid[1] ? 1 : 0;
        for (int i = 0; i < W; i++) begin
            if (disp_inst_valid[i]) begin
                pend.push_back(disp_tag[i].seq);
                br_wait[disp_tag[i].seq] = 1'b0;
            end
        end
        if (branch) begin
            br_push                            = 1'b1;
            br_tag                             = disp_tag[last];
            br_wait[disp_tag[last].seq]        = 1'b1;
            br_wait_miss[disp_tag[last].seq]   = miss;
            br_wait_target[disp_tag[last].seq] = $urandom;
        end
        tick();
        disp_valid = 1'b0;
        br_push    = 1'b0;
    endtask

    task automatic dispatch(logic [W-1:0] mask, int a0, int a1, bit branch, bit miss);
        offer(mask, a0, a1);
        accept(branch, miss);
    endtask

    // random pick of pending tags, branch resolves with its completion
    task automatic complete_step();
        int idx;
        int t;
        for (int k = 0; k < `CDB_WIDTH; k++) begin
            if (pend.size() != 0) begin
                idx = $urandom_range(pend.size() - 1);
                t   = pend[idx];
                pend.delete(idx);
                if (br_wait[t] && br_resolve) begin
                    pend.push_back(t);   // one resolve port
                end else begin
                    cdb_valid[k]   = 1'b1;
                    cdb_tag[k].seq = t;
                    if (br_wait[t]) begin
                        br_resolve         = 1'b1;
                        br_resolve_tag.seq = t;
                        br_miss            = br_wait_miss[t];
                        br_target          = br_wait_target[t];
                        br_wait[t]         = 1'b0;
                    end
                end
            end
        end
        tick();
        cdb_valid  = '0;
        br_resolve = 1'b0;
    endtask

    task automatic drain();
        while (row_base.size() != 0) complete_step();
    endtask

    initial begin
        void'($urandom(95));
        rst = 1'b1;
        cycles = 0;
        disp_valid = 1'b0;
        disp_inst_valid = '0;
        disp_rd_phy = '0;
        disp_rd_arch = '0;
        cdb_valid = '0;
        cdb_tag = '0;
        br_push = 1'b0;
        br_tag = '0;
        br_resolve = 1'b0;
        br_resolve_tag = '0;
        br_miss = 1'b0;
        br_target = '0;
        next_tag = 0;
        test_name = "reset";
        for (int r = 0; r < 32; r++) arch_map[r] = backend_pkg::phy_reg_t'(r);
        repeat (4) @(posedge clk);
        #10;
        rst = 1'b0;

        test_name = "freed_regs";
        dispatch(2'b11, 7, 7, 0, 0);   // same rd_arch twice in one row
        dispatch(2'b11, 0, 5, 0, 0);
        dispatch(2'b01, 0, 0, 0, 0);
        drain();

        test_name = "commit_order";
        repeat (12) begin
            dispatch($urandom_range(1, 3), $urandom_range(31), $urandom_range(31), 0, 0);
            if ($urandom_range(1) == 1) complete_step();
        end
        drain();

        test_name = "full_buffer";
        repeat (`ROB_DEPTH) dispatch(2'b11, $urandom_range(31), $urandom_range(31), 0, 0);
        offer(2'b11, $urandom_range(31), $urandom_range(31));
        repeat (3) tick();   // held while full
        cdb_valid         = 2'b11;
        cdb_tag[0].seq    = pend[0];
        cdb_tag[1].seq    = pend[1];
        void'(pend.pop_front());
        void'(pend.pop_front());
        tick();
        cdb_valid = '0;
        accept(0, 0);
        drain();

        test_name = "branch_ok";
        dispatch(2'b11, $urandom_range(31), $urandom_range(31), 1, 0);
        dispatch(2'b01, $urandom_range(31), 0, 1, 0);
        drain();

        test_name = "mispredict";
        dispatch(2'b11, $urandom_range(31), $urandom_range(31), 1, 1);
        dispatch(2'b11, $urandom_range(31), $urandom_range(31), 0, 0);
        dispatch(2'b10, 0, $urandom_range(31), 1, 0);   // younger branch goes too
        drain();
        repeat (2) tick();
        test_name = "after_flush";
        repeat (`CB_DEPTH) begin
            dispatch(2'b01, $urandom_range(31), 0, 1, 0);
            drain();
        end

        repeat (3) tick();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- rob_backend.f
+incdir+rtl
rtl/backend_pkg.sv
rtl/backend_itf.sv
rtl/rob.sv
rtl/rrf.sv
rtl/control_buffer.sv
rtl/rob_backend.sv
tests/tb_clock.sv
tests/rob_backend_checker.sv
tests/rob_backend_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= rob_backend_tb
FILELIST  ?= rob_backend.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing

SOURCES := $(wildcard rtl/*.sv rtl/*.svh tests/*.sv)

.PHONY: all run build lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
